/* rv_pkg.sv */
// core widths, nop encoding, opcode/alu/branch encodings, decoded-instruction and redirect structs
package rv_pkg;

    localparam int XLEN       = 64;           // register and address width
    localparam int ILEN       = 32;           // instruction width
    localparam int REG_ADDR_W = 5;            // 32 architectural registers

    localparam logic [ILEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

    // major opcodes kept by this core, anything else runs as a no-op
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP     = 7'b0110011,   // register-register
        OPC_OP_IMM = 7'b0010011,   // register-immediate
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                   // signed compare
        ALU_SLTU,                  // unsigned compare
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // branch kinds as they appear in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_DOUBLE = 3'b011;  // ld / sd, the only width kept

    // one instruction after decode
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;       // already sign-extended for its format
        opcode_e               op;
        alu_op_e               alu_op;
        logic [2:0]            funct3;    // branch condition select
        logic                  use_imm;   // alu operand b from imm instead of rs2
        logic                  write_rd;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
    } decoded_t;

    // pc change requested by execute
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

/* alu.sv */
// alu module: 64-bit add/sub, bitwise logic, signed and unsigned compare, shifts
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_e         alu_op,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    output logic [rv_pkg::XLEN-1:0] result
);

    logic [5:0] shamt;        // rv64 shifts use 6 bits
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[5:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD: begin
                result = a + b;
            end
            rv_pkg::ALU_SUB: begin
                result = a - b;
            end
            rv_pkg::ALU_AND: begin
                result = a & b;
            end
            rv_pkg::ALU_OR: begin
                result = a | b;
            end
            rv_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            rv_pkg::ALU_SLT: begin
                result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            rv_pkg::ALU_SLTU: begin
                result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            rv_pkg::ALU_SRL: begin
                result = a >> shamt;                   // zero fill
            end
            rv_pkg::ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);  // sign fill
            end
            default: begin
                result = a + b;                        // unused encodings
            end
        endcase
    end

endmodule

/* reg_file.sv */
// reg_file module: 32 x 64-bit registers, two async reads, one clocked write, x0 tied to zero
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk_1hz,
    input  logic                          reset_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]       wdata
);

    localparam int NUM_REGS = 1 << rv_pkg::REG_ADDR_W;

    logic [rv_pkg::XLEN-1:0] regs [NUM_REGS];

    // all registers start at zero so untouched ones read clean
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // x0 write dropped
            regs[waddr] <= wdata;
        end
    end

    // no bypass needed, write lands at the edge before the next read
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* instr_decode.sv */
// instr_decode module: field split, immediate build, alu op mapping and class flags
`timescale 1ns/1ps

module instr_decode (
    input  logic [rv_pkg::ILEN-1:0] instr,
    output rv_pkg::decoded_t        decoded
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic                    alt;        // instr[30], picks sub / sra
    logic                    op_ok;      // funct7 legal for register-register
    logic                    shift_ok;   // upper imm bits legal for shift-immediate
    rv_pkg::alu_op_e         arith_op;   // shared by OP and OP_IMM

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = instr[30];

    // sign-extended immediates, one per format
    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign op_ok = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    // shamt is 6 bits on rv64 so only instr[31:26] is checked
    assign shift_ok = (funct3 == 3'b001) ? (instr[31:26] == 6'b000000) :
                      (funct3 == 3'b101) ? (instr[31:26] == 6'b000000 ||
                                            instr[31:26] == 6'b010000) : 1'b1;

    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == rv_pkg::OPC_OP && alt) ? rv_pkg::ALU_SUB
                                                                  : rv_pkg::ALU_ADD;
            3'b001: arith_op = rv_pkg::ALU_SLL;
            3'b010: arith_op = rv_pkg::ALU_SLT;
            3'b011: arith_op = rv_pkg::ALU_SLTU;
            3'b100: arith_op = rv_pkg::ALU_XOR;
            3'b101: arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110: arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;   // 111
        endcase
    end

    always_comb begin
        decoded        = '0;                       // unknown opcode leaves every flag clear
        decoded.rd     = instr[11:7];
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.funct3 = funct3;
        decoded.op     = rv_pkg::opcode_e'(opcode);
        decoded.alu_op = rv_pkg::ALU_ADD;          // address and upper-imm math
        decoded.imm    = imm_i;
        case (opcode)
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
                decoded.imm      = imm_u;
                decoded.use_imm  = 1'b1;
                decoded.write_rd = 1'b1;
            end
            rv_pkg::OPC_OP: begin
                decoded.alu_op   = arith_op;
                decoded.write_rd = op_ok;
            end
            rv_pkg::OPC_OP_IMM: begin
                decoded.alu_op   = arith_op;
                decoded.use_imm  = 1'b1;
                decoded.write_rd = shift_ok;
            end
            rv_pkg::OPC_LOAD: begin
                decoded.use_imm  = 1'b1;
                decoded.is_load  = (funct3 == rv_pkg::F3_DOUBLE);
                decoded.write_rd = (funct3 == rv_pkg::F3_DOUBLE);
            end
            rv_pkg::OPC_STORE: begin
                decoded.imm      = imm_s;
                decoded.use_imm  = 1'b1;
                decoded.is_store = (funct3 == rv_pkg::F3_DOUBLE);
            end
            rv_pkg::OPC_JAL: begin
                decoded.imm      = imm_j;
                decoded.is_jal   = 1'b1;
                decoded.write_rd = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                decoded.use_imm  = 1'b1;                // rs1 + imm through the alu
                decoded.is_jalr  = (funct3 == 3'b000);
                decoded.write_rd = (funct3 == 3'b000);
            end
            rv_pkg::OPC_BRANCH: begin
                decoded.imm       = imm_b;
                decoded.is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            default: ;
        endcase
    end

endmodule

/* instr_fetch.sv */
// instr_fetch module: program counter, instruction register, valid flag and redirect handling
`timescale 1ns/1ps

module instr_fetch #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk_1hz,
    input  logic                    reset_n,
    input  rv_pkg::redirect_t       redirect,     // from execute, same cycle
    output logic [rv_pkg::XLEN-1:0] i_mem_addr,
    input  logic [rv_pkg::ILEN-1:0] i_mem_data,
    output logic [rv_pkg::ILEN-1:0] instr,        // word executed this cycle
    output logic                    instr_valid,  // low for the squashed slot
    output logic [rv_pkg::XLEN-1:0] pc,           // current fetch address
    output logic [rv_pkg::XLEN-1:0] instr_pc      // address of instr
);

    logic [rv_pkg::XLEN-1:0] pc_next;

    // jump target wins over sequential step
    assign pc_next    = redirect.taken ? redirect.target : pc + rv_pkg::XLEN'(4);
    assign i_mem_addr = pc;   // memory answers combinationally

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc          <= RESET_PC;
            instr       <= rv_pkg::NOP_INSTR;
            instr_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (redirect.taken) begin
                // fall-through word was fetched in the wrong path, drop it
                instr       <= rv_pkg::NOP_INSTR;
                instr_valid <= 1'b0;
            end else begin
                instr       <= i_mem_data;
                instr_valid <= 1'b1;
            end
        end
    end

    // address travels alongside its word, only meaningful while instr_valid
    always_ff @(posedge clk_1hz) begin
        instr_pc <= pc;
    end

endmodule

/* exec_stage.sv */
// exec_stage module: operand select, branch decision, load/store drive, write-back and redirect
`timescale 1ns/1ps

module exec_stage (
    input  logic                          instr_valid,
    input  logic [rv_pkg::XLEN-1:0]       instr_pc,
    input  rv_pkg::decoded_t              decoded,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data,
    output logic                          we,
    output logic [rv_pkg::REG_ADDR_W-1:0] waddr,
    output logic [rv_pkg::XLEN-1:0]       wdata,
    output rv_pkg::redirect_t             redirect,
    output logic [rv_pkg::XLEN-1:0]       mem_addr,
    output logic [rv_pkg::XLEN-1:0]       mem_wdata,
    output logic                          mem_we,
    input  logic [rv_pkg::XLEN-1:0]       mem_rdata
);

    logic [rv_pkg::XLEN-1:0] alu_a;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] pc_target;    // branch and jal destination
    logic [rv_pkg::XLEN-1:0] link_addr;    // return address for jumps
    logic                    branch_cond;
    logic                    jump;

    // auipc adds to its own pc, lui adds to zero
    assign alu_a = (decoded.op == rv_pkg::OPC_AUIPC) ? instr_pc :
                   (decoded.op == rv_pkg::OPC_LUI)   ? '0       : rs1_data;
    assign alu_b = decoded.use_imm ? decoded.imm : rs2_data;

    alu u_alu (
        .alu_op (decoded.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    assign pc_target = instr_pc + decoded.imm;
    assign link_addr = instr_pc + rv_pkg::XLEN'(4);

    always_comb begin
        case (decoded.funct3)
            rv_pkg::F3_BEQ:  branch_cond = (rs1_data == rs2_data);
            rv_pkg::F3_BNE:  branch_cond = (rs1_data != rs2_data);
            rv_pkg::F3_BLT:  branch_cond = ($signed(rs1_data) <  $signed(rs2_data));
            rv_pkg::F3_BGE:  branch_cond = ($signed(rs1_data) >= $signed(rs2_data));
            rv_pkg::F3_BLTU: branch_cond = (rs1_data <  rs2_data);
            rv_pkg::F3_BGEU: branch_cond = (rs1_data >= rs2_data);
            default:         branch_cond = 1'b0;   // decode already blocks these
        endcase
    end

    assign jump = decoded.is_jal | decoded.is_jalr;

    // a squashed slot can neither redirect nor write anything
    assign redirect.taken  = instr_valid && (jump || (decoded.is_branch && branch_cond));
    assign redirect.target = decoded.is_jalr ? {alu_result[rv_pkg::XLEN-1:1], 1'b0}
                                             : pc_target;

    assign we    = instr_valid && decoded.write_rd;
    assign waddr = decoded.rd;
    assign wdata = jump            ? link_addr :
                   decoded.is_load ? mem_rdata : alu_result;

    assign mem_addr  = alu_result;        // rs1 + imm for ld / sd
    assign mem_wdata = rs2_data;
    assign mem_we    = instr_valid && decoded.is_store;   // one cycle per sd

endmodule

/* rv_core.sv */
// rv_core top level: fetch, decode, register file and execute wired together
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk_1hz,
    input  logic                    reset_n,
    output logic [rv_pkg::XLEN-1:0] i_mem_addr,
    input  logic [rv_pkg::ILEN-1:0] i_mem_data,
    output logic [rv_pkg::XLEN-1:0] mem_addr,
    output logic [rv_pkg::XLEN-1:0] mem_wdata,
    output logic                    mem_we,
    input  logic [rv_pkg::XLEN-1:0] mem_rdata
);

    logic [rv_pkg::ILEN-1:0]       instr;
    logic                          instr_valid;
    logic [rv_pkg::XLEN-1:0]       instr_pc;
    rv_pkg::decoded_t              decoded;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic                          rf_we;
    logic [rv_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [rv_pkg::XLEN-1:0]       rf_wdata;
    rv_pkg::redirect_t             redirect;      // execute back to fetch

    instr_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_1hz     (clk_1hz),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .i_mem_addr  (i_mem_addr),
        .i_mem_data  (i_mem_data),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (),               // same value as i_mem_addr
        .instr_pc    (instr_pc)
    );

    instr_decode u_decode (
        .instr   (instr),
        .decoded (decoded)
    );

    reg_file u_regs (
        .clk_1hz  (clk_1hz),
        .reset_n  (reset_n),
        .rs1      (decoded.rs1),
        .rs2      (decoded.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    exec_stage u_exec (
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .decoded     (decoded),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .we          (rf_we),
        .waddr       (rf_waddr),
        .wdata       (rf_wdata),
        .redirect    (redirect),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* tb_rv_core_sva.sv */
// tb_rv_core_sva module: bound checks on reset store gating, fetch stepping, alignment, fail count
`timescale 1ns/1ps

module tb_rv_core_sva (
    input logic              clk_1hz,
    input logic              reset_n,
    input logic [63:0]       i_mem_addr,
    input logic              mem_we,
    input rv_pkg::redirect_t redirect
);

    int fail_count = 0;   // summed into the testbench totals

    // no store can leave while held in reset
    assert property (@(posedge clk_1hz) !reset_n |-> !mem_we)
        else begin
            $error("mem_we high during reset");
            fail_count++;
        end

    // sequential fetch unless execute redirected on the edge before
    assert property (@(posedge clk_1hz) disable iff (!reset_n)
        ($past(reset_n) && !$past(redirect.taken)) |-> i_mem_addr == $past(i_mem_addr) + 64'd4)
        else begin
            $error("i_mem_addr did not step by 4");
            fail_count++;
        end

    assert property (@(posedge clk_1hz) i_mem_addr[1:0] == 2'b00)
        else begin
            $error("i_mem_addr not word aligned");
            fail_count++;
        end

endmodule

bind rv_core tb_rv_core_sva u_sva (.*);

/* tb_rv_core.sv */
// tb_rv_core testbench: clock, reset, instruction and data memory models, file-driven checks, watchdog
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [63:0] RESET_PC = 64'h0;
    localparam int          IMEM_WORDS = 256;
    localparam int          DMEM_WORDS = 128;

    logic        clk_1hz;
    logic        reset_n;
    logic [63:0] i_mem_addr;
    logic [31:0] i_mem_data;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;
    logic        mem_we;
    logic [63:0] mem_rdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [63:0] dmem [DMEM_WORDS];
    logic [63:0] exp_st_addr[$];
    logic [63:0] exp_st_data[$];
    logic [63:0] exp_redir[$];
    int          fd;
    int          icount;
    int          st_idx, rd_idx;
    int          chk_reset, chk_store, chk_redir;
    int          err_reset, err_store, err_redir, err_end;
    int          err_sva, err_total;
    logic        loaded;
    logic        seen_edge;        // first clock edge after reset has passed
    logic        prev_ok;
    logic [63:0] prev_addr;

    rv_core #(.RESET_PC(RESET_PC)) dut (.*);

    initial begin
        clk_1hz = 1'b0;
        forever #10 clk_1hz = ~clk_1hz;    // 20 ns period
    end

    // memories answer combinationally, out-of-range fetch sees a nop
    assign i_mem_data = (i_mem_addr < 64'(IMEM_WORDS * 4)) ? imem[i_mem_addr[9:2]] : 32'h13;
    assign mem_rdata  = dmem[mem_addr[9:3]];

    always @(posedge clk_1hz) begin
        if (mem_we) dmem[mem_addr[9:3]] <= mem_wdata;
        if (reset_n) seen_edge <= 1'b1;
    end

    // skips comment and blank lines, returns the next data line
    task automatic read_line(output string line);
        int   rc;
        logic found;
        found = 1'b0;
        line  = "";
        while (!found && !$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 1 && line.substr(0, 1) != "//") found = 1'b1;
        end
    endtask

    task automatic load_program();
        string       line;
        int          n, rc;
        logic [63:0] a, d;
        read_line(line);
        rc = $sscanf(line, "%h", icount);
        for (int i = 0; i < icount; i++) begin
            read_line(line);
            rc = $sscanf(line, "%h", a);
            imem[i] = a[31:0];
        end
        read_line(line);
        rc = $sscanf(line, "%h", n);              // data preload pairs
        for (int i = 0; i < n; i++) begin
            read_line(line);
            rc = $sscanf(line, "%h %h", a, d);
            dmem[a[9:3]] = d;
        end
        read_line(line);
        rc = $sscanf(line, "%h", n);              // expected stores
        for (int i = 0; i < n; i++) begin
            read_line(line);
            rc = $sscanf(line, "%h %h", a, d);
            exp_st_addr.push_back(a);
            exp_st_data.push_back(d);
        end
        read_line(line);
        rc = $sscanf(line, "%h", n);              // expected redirect targets
        for (int i = 0; i < n; i++) begin
            read_line(line);
            rc = $sscanf(line, "%h", a);
            exp_redir.push_back(a);
        end
    endtask

    // all sampling on the falling edge, away from the rising-edge updates
    always @(negedge clk_1hz) begin
        if (!reset_n || !seen_edge) begin
            chk_reset++;
            assert (i_mem_addr == RESET_PC) else begin
                $display("ERROR t=%0t i_mem_addr exp=%h got=%h", $time, RESET_PC, i_mem_addr);
                err_reset++;
            end
            assert (!mem_we) else begin
                $display("ERROR t=%0t mem_we exp=0 got=%b", $time, mem_we);
                err_reset++;
            end
        end
        if (reset_n && mem_we) begin
            chk_store++;
            assert (st_idx < exp_st_addr.size()) else begin
                $display("t=%0t unexpected extra store to %h", $time, mem_addr);
                err_store++;
            end
            if (st_idx < exp_st_addr.size()) begin
                assert (mem_addr == exp_st_addr[st_idx]) else begin
                    $display("ERROR t=%0t mem_addr exp=%h got=%h", $time,
                             exp_st_addr[st_idx], mem_addr);
                    err_store++;
                end
                assert (mem_wdata == exp_st_data[st_idx]) else begin
                    $display("ERROR t=%0t mem_wdata exp=%h got=%h", $time,
                             exp_st_data[st_idx], mem_wdata);
                    err_store++;
                end
            end
            st_idx++;
        end
        if (reset_n && prev_ok && i_mem_addr != prev_addr + 64'd4) begin   // jump seen
            chk_redir++;
            assert (rd_idx < exp_redir.size()) else begin
                $display("t=%0t unexpected redirect to %h", $time, i_mem_addr);
                err_redir++;
            end
            if (rd_idx < exp_redir.size()) begin
                assert (i_mem_addr == exp_redir[rd_idx]) else begin
                    $display("ERROR t=%0t i_mem_addr exp=%h got=%h", $time,
                             exp_redir[rd_idx], i_mem_addr);
                    err_redir++;
                end
            end
            rd_idx++;
        end
        prev_ok   = reset_n;
        prev_addr = i_mem_addr;
    end

    // watchdog scaled by program length
    initial begin
        wait (loaded);
        repeat ((icount + 50) * 10) @(posedge clk_1hz);
        $display("watchdog: program did not run to its end in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset_n   = 1'b0;
        loaded    = 1'b0;
        seen_edge = 1'b0;
        prev_ok   = 1'b0;
        prev_addr = '0;
        {st_idx, rd_idx, chk_reset, chk_store, chk_redir} = '0;
        {err_reset, err_store, err_redir, err_end, err_sva, err_total} = '0;
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = 32'h13;
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = {32'(i * 8), ~32'(i * 8)};
        fd = $fopen("program_input.hex", "r");
        if (fd == 0) begin
            $display("could not open program_input.hex");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            load_program();
            $fclose(fd);
            loaded = 1'b1;
            repeat (10) @(posedge clk_1hz);
            #2 reset_n = 1'b1;
            // done once the last word has left execute
            while (i_mem_addr < 64'(icount * 4 + 8)) @(negedge clk_1hz);
            repeat (2) @(posedge clk_1hz);
            assert (st_idx == exp_st_addr.size()) else begin
                $display("store count wrong: saw %0d, expected %0d", st_idx,
                         exp_st_addr.size());
                err_end++;
            end
            assert (rd_idx == exp_redir.size()) else begin
                $display("redirect count wrong: saw %0d, expected %0d", rd_idx,
                         exp_redir.size());
                err_end++;
            end
            err_sva   = dut.u_sva.fail_count;
            err_total = err_reset + err_store + err_redir + err_end + err_sva;
            $display("reset: %0d checks, %0d errors", chk_reset, err_reset);
            $display("stores: %0d checks, %0d errors", chk_store, err_store);
            $display("redirects: %0d checks, %0d errors", chk_redir, err_redir);
            $display("bound assertions: %0d failures", err_sva);
            $display("totals: %0d checks, %0d errors", chk_reset + chk_store + chk_redir,
                     err_total);
            if (err_total == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

/* program_input.hex */
// hex values: instr count, instr words, preload count, addr data pairs,
// store count, addr data pairs, redirect count, target addresses
3b
10000513
ffb00093
00300113
402081b3
00353023
4010d213
00453423
03c0d293
00553823
80000337
002323b3
00233433
00853c23
002394b3
0014c5b3
0065f633
00966633
02c53023
00001697
02d53423
10053703
ff070713
02e53823
00210663
00153023
00153023
00209663
00153023
00153023
0020c663
00153023
00153023
00115663
00153023
00153023
00116663
00153023
00153023
0020f663
00153023
00153023
00208463
00211463
00114463
0020d463
0020e463
00117463
02253c23
00c007ef
00153023
00153023
04f53023
0e000813
001808e7
00153023
00153023
05153423
7ff00013
04053823
// data preload
1
200 123456789abcdef0
// expected stores
b
100 fffffffffffffff8
108 fffffffffffffffd
110 000000000000000f
118 0000000000000000
120 ffffffff80000008
128 0000000000001048
130 123456789abcdee0
138 0000000000000003
140 00000000000000c4
148 00000000000000d8
150 0000000000000000
// expected redirect targets
8
68
74
80
8c
98
a4
cc
e0

/* all.f */
rv_pkg.sv
alu.sv
reg_file.sv
instr_decode.sv
instr_fetch.sv
exec_stage.sv
rv_core.sv
tb_rv_core_sva.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
